/* verilog/magic_seq_defines.svh */
`ifndef MAGIC_SEQ_DEFINES_SVH
`define MAGIC_SEQ_DEFINES_SVH

// bus and field widths
`define MS_ADDR_W       32      // global address seen by the dma
`define MS_DATA_W       32
`define MS_REG_ADDR_W   16      // host register window
`define MS_SIZE_W       26      // dma transfer size field
`define MS_SLOT_W       2
`define MS_SLOT_COUNT   4

// bank0 control registers
`define MS_REG_CONTROL  'h00    // bit0 starts a run
`define MS_REG_STATUS   'h04    // busy in bit0 and done in bit1
`define MS_REG_MAIN_CNT 'h08    // slot now running
`define MS_REG_END_CNT  'h0C    // last slot of a run
`define MS_REG_DMA_BASE 'h10    // dma register base on the master bus

// bank1 slot table with 0x10 bytes per slot
`define MS_BANK1_BASE   'h100

// dma engine registers, relative to dma_base
`define MS_DMA_SRC_ADDR_OFS 'h00
`define MS_DMA_SRC_SIZE_OFS 'h04
`define MS_DMA_DST_ADDR_OFS 'h08
`define MS_DMA_DST_SIZE_OFS 'h0C
`define MS_DMA_START_OFS    'h10
`define MS_DMA_START_VALUE  1

`endif

/* verilog/magic_seq_pkg.sv */
`include "magic_seq_defines.svh"

package magic_seq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`MS_ADDR_W-1:0]     addr_t;      // global bus address
    typedef logic [`MS_DATA_W-1:0]     data_t;      // one bus word
    typedef logic [`MS_REG_ADDR_W-1:0] reg_addr_t;  // host register offset
    typedef logic [`MS_SIZE_W-1:0]     size_t;      // dma byte count
    typedef logic [`MS_SLOT_W-1:0]     slot_idx_t;  // table index and run counter

    ////////////////////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,        // waiting for a start write
        st_issue,       // command pulse toward the writer
        st_wait_cmd,    // writer busy on the master bus
        st_wait_fin,    // dma working on the slot
        st_next         // last slot check
    } seq_state_t;

endpackage

/* verilog/reg_axi_write.sv */
`timescale 1ns/100ps
`include "magic_seq_defines.svh"

module reg_axi_write (
    input  logic                     clk,
    input  logic                     reset,
    input  magic_seq_pkg::reg_addr_t S_AXI_AWADDR,
    input  logic                     S_AXI_AWVALID,
    output logic                     S_AXI_AWREADY,
    input  magic_seq_pkg::data_t     S_AXI_WDATA,
    input  logic                     S_AXI_WVALID,
    output logic                     S_AXI_WREADY,
    output logic [1:0]               S_AXI_BRESP,
    output logic                     S_AXI_BVALID,
    input  logic                     S_AXI_BREADY,
    output logic                     set_control,
    output logic                     set_end_cnt,
    output logic                     set_dma_base,
    output logic                     set_slot_field,
    output magic_seq_pkg::slot_idx_t wr_slot,
    output logic [1:0]               wr_field,
    output magic_seq_pkg::data_t     wr_data
);
    import magic_seq_pkg::*;

    localparam int        tbl_lsb    = $clog2(`MS_SLOT_COUNT) + 4;  // 16 bytes a slot
    localparam reg_addr_t bank1_base = `MS_BANK1_BASE;

    logic accept;       // address and data taken this cycle
    logic bank1_hit;

    // one ready pulse per paired beat, none while a response waits
    always_ff @(posedge clk) begin
        if (reset) begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_BVALID  <= 1'b0;
        end else begin
            S_AXI_AWREADY <= S_AXI_AWVALID && S_AXI_WVALID
                             && !S_AXI_BVALID && !S_AXI_AWREADY;
            if (accept)
                S_AXI_BVALID <= 1'b1;
            else if (S_AXI_BREADY)
                S_AXI_BVALID <= 1'b0;   // host took the response
        end
    end

    assign S_AXI_WREADY = S_AXI_AWREADY;  // both channels move together
    assign S_AXI_BRESP  = 2'b00;          // OKAY, unmapped writes too
    assign accept       = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID;

    ////////////////////////////////////////////////////////////////////////////
    // address decode into one strobe
    ////////////////////////////////////////////////////////////////////////////

    assign bank1_hit = S_AXI_AWADDR[`MS_REG_ADDR_W-1:tbl_lsb]
                       == bank1_base[`MS_REG_ADDR_W-1:tbl_lsb];

    assign set_control    = accept && S_AXI_AWADDR == `MS_REG_CONTROL;
    assign set_end_cnt    = accept && S_AXI_AWADDR == `MS_REG_END_CNT;
    assign set_dma_base   = accept && S_AXI_AWADDR == `MS_REG_DMA_BASE;
    assign set_slot_field = accept && bank1_hit;

    assign wr_slot  = S_AXI_AWADDR[tbl_lsb-1:4];  // slot within the table
    assign wr_field = S_AXI_AWADDR[3:2];          // word within the slot
    assign wr_data  = S_AXI_WDATA;

    // response must wait for the host
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

endmodule

/* verilog/reg_axi_read.sv */
`timescale 1ns/100ps

module reg_axi_read (
    input  logic                     clk,
    input  logic                     reset,
    input  magic_seq_pkg::reg_addr_t S_AXI_ARADDR,
    input  logic                     S_AXI_ARVALID,
    output logic                     S_AXI_ARREADY,
    output magic_seq_pkg::data_t     S_AXI_RDATA,
    output logic [1:0]               S_AXI_RRESP,
    output logic                     S_AXI_RVALID,
    input  logic                     S_AXI_RREADY,
    output magic_seq_pkg::reg_addr_t rd_addr,
    input  magic_seq_pkg::data_t     rd_data
);
    import magic_seq_pkg::*;

    logic accept;   // read address taken this cycle

    assign accept      = S_AXI_ARREADY && S_AXI_ARVALID;
    assign rd_addr     = S_AXI_ARADDR;  // register bank answers in the same cycle
    assign S_AXI_RRESP = 2'b00;         // always OKAY

    // arready stays up whenever no read data is pending
    always_ff @(posedge clk) begin
        if (reset) begin
            S_AXI_ARREADY <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
        end else if (accept) begin
            S_AXI_ARREADY <= 1'b0;
            S_AXI_RVALID  <= 1'b1;
        end else if (S_AXI_RVALID) begin
            S_AXI_RVALID  <= !S_AXI_RREADY;  // hold until taken
            S_AXI_ARREADY <= S_AXI_RREADY;
        end else begin
            S_AXI_ARREADY <= 1'b1;
        end
    end

    // snapshot of the register, stable while rvalid waits
    always_ff @(posedge clk) begin
        if (accept)
            S_AXI_RDATA <= rd_data;
    end

    // data must not move under a stalled read
    a_rdata_hold: assert property (@(posedge clk) disable iff (reset)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

/* verilog/seq_regs.sv */
`timescale 1ns/100ps
`include "magic_seq_defines.svh"

module seq_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     set_control,
    input  logic                     set_end_cnt,
    input  logic                     set_dma_base,
    input  logic                     set_slot_field,
    input  magic_seq_pkg::slot_idx_t wr_slot,
    input  logic [1:0]               wr_field,
    input  magic_seq_pkg::data_t     wr_data,
    input  magic_seq_pkg::reg_addr_t rd_addr,
    output magic_seq_pkg::data_t     rd_data,
    input  logic                     busy,
    input  logic                     done,
    input  magic_seq_pkg::slot_idx_t main_cnt,
    output logic                     start_pulse,
    output magic_seq_pkg::slot_idx_t end_cnt,
    output magic_seq_pkg::addr_t     dma_base,
    input  magic_seq_pkg::slot_idx_t slot,
    output magic_seq_pkg::addr_t     slot_src_addr,
    output magic_seq_pkg::size_t     slot_src_size,
    output magic_seq_pkg::addr_t     slot_dst_addr,
    output magic_seq_pkg::size_t     slot_dst_size
);
    import magic_seq_pkg::*;

    localparam int        tbl_lsb    = $clog2(`MS_SLOT_COUNT) + 4;
    localparam reg_addr_t bank1_base = `MS_BANK1_BASE;

    addr_t     src_addr_mem [`MS_SLOT_COUNT];  // bank1 slot table
    size_t     src_size_mem [`MS_SLOT_COUNT];
    addr_t     dst_addr_mem [`MS_SLOT_COUNT];
    size_t     dst_size_mem [`MS_SLOT_COUNT];
    slot_idx_t rd_slot;

    ////////////////////////////////////////////////////////////////////////////
    // bank0
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            start_pulse <= 1'b0;
            end_cnt     <= '0;
            dma_base    <= '0;
        end else begin
            start_pulse <= set_control && wr_data[0] && !busy;  // dropped while running
            if (set_end_cnt)
                end_cnt <= wr_data[`MS_SLOT_W-1:0];
            if (set_dma_base)
                dma_base <= wr_data;
        end
    end

    // bank1, whole word writes
    always_ff @(posedge clk) begin
        if (set_slot_field) begin
            case (wr_field)
                2'd0: src_addr_mem[wr_slot] <= wr_data;
                2'd1: src_size_mem[wr_slot] <= wr_data[`MS_SIZE_W-1:0];
                2'd2: dst_addr_mem[wr_slot] <= wr_data;
                2'd3: dst_size_mem[wr_slot] <= wr_data[`MS_SIZE_W-1:0];
            endcase
        end
    end

    // engine side read port
    assign slot_src_addr = src_addr_mem[slot];
    assign slot_src_size = src_size_mem[slot];
    assign slot_dst_addr = dst_addr_mem[slot];
    assign slot_dst_size = dst_size_mem[slot];

    // host read mux, anything unmapped gives zero
    assign rd_slot = rd_addr[tbl_lsb-1:4];

    always_comb begin
        rd_data = '0;
        if (rd_addr[`MS_REG_ADDR_W-1:tbl_lsb] == bank1_base[`MS_REG_ADDR_W-1:tbl_lsb]) begin
            case (rd_addr[3:2])
                2'd0: rd_data = src_addr_mem[rd_slot];
                2'd1: rd_data = data_t'(src_size_mem[rd_slot]);
                2'd2: rd_data = dst_addr_mem[rd_slot];
                2'd3: rd_data = data_t'(dst_size_mem[rd_slot]);
            endcase
        end else begin
            case (rd_addr)
                `MS_REG_STATUS:   rd_data = data_t'({done, busy});
                `MS_REG_MAIN_CNT: rd_data = data_t'(main_cnt);
                `MS_REG_END_CNT:  rd_data = data_t'(end_cnt);
                `MS_REG_DMA_BASE: rd_data = dma_base;
                default:          rd_data = '0;  // control reads back zero
            endcase
        end
    end

endmodule

/* verilog/seq_engine.sv */
`timescale 1ns/100ps
`include "magic_seq_defines.svh"

module seq_engine (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_pulse,
    input  magic_seq_pkg::slot_idx_t end_cnt,
    input  magic_seq_pkg::addr_t     dma_base,
    input  logic                     slave_fin_exec,
    input  magic_seq_pkg::addr_t     slot_src_addr,
    input  magic_seq_pkg::size_t     slot_src_size,
    input  magic_seq_pkg::addr_t     slot_dst_addr,
    input  magic_seq_pkg::size_t     slot_dst_size,
    output magic_seq_pkg::slot_idx_t slot,
    output logic                     busy,
    output logic                     done,
    output magic_seq_pkg::slot_idx_t main_cnt,
    output logic                     cmd_valid,
    output magic_seq_pkg::addr_t     cmd_addr,
    output magic_seq_pkg::data_t     cmd_data,
    input  logic                     cmd_done
);
    import magic_seq_pkg::*;

    localparam logic [2:0] last_field = 3'd4;  // the start write

    seq_state_t state;
    logic [2:0] field;      // 0..3 init words then start
    addr_t      cmd_ofs;

    assign slot = main_cnt;  // table port follows the running slot

    ////////////////////////////////////////////////////////////////////////////
    // command word for the current field
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (field)
            3'd0:    cmd_ofs = `MS_DMA_SRC_ADDR_OFS;
            3'd1:    cmd_ofs = `MS_DMA_SRC_SIZE_OFS;
            3'd2:    cmd_ofs = `MS_DMA_DST_ADDR_OFS;
            3'd3:    cmd_ofs = `MS_DMA_DST_SIZE_OFS;
            default: cmd_ofs = `MS_DMA_START_OFS;
        endcase
        case (field)
            3'd0:    cmd_data = slot_src_addr;
            3'd1:    cmd_data = data_t'(slot_src_size);
            3'd2:    cmd_data = slot_dst_addr;
            3'd3:    cmd_data = data_t'(slot_dst_size);
            default: cmd_data = `MS_DMA_START_VALUE;
        endcase
    end

    assign cmd_addr = dma_base + cmd_ofs;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            field     <= '0;
            main_cnt  <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;  // pulse, set again on entry to issue
            case (state)
                st_idle: begin
                    if (start_pulse) begin
                        busy      <= 1'b1;
                        done      <= 1'b0;  // previous run forgotten
                        main_cnt  <= '0;
                        field     <= '0;
                        cmd_valid <= 1'b1;
                        state     <= st_issue;
                    end
                end
                st_issue: state <= st_wait_cmd;
                st_wait_cmd: begin
                    if (cmd_done && field == last_field) begin
                        state <= st_wait_fin;
                    end else if (cmd_done) begin
                        field     <= field + 3'd1;
                        cmd_valid <= 1'b1;
                        state     <= st_issue;
                    end
                end
                st_wait_fin: begin
                    if (slave_fin_exec)
                        state <= st_next;
                end
                st_next: begin
                    if (main_cnt == end_cnt) begin  // run complete
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= st_idle;
                    end else begin
                        main_cnt  <= main_cnt + 1'b1;
                        field     <= '0;
                        cmd_valid <= 1'b1;
                        state     <= st_issue;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // commands leave only from issue, never two in a row
    a_cmd_in_issue: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> (state == st_issue) ##1 !cmd_valid);

endmodule

/* verilog/dma_cmd_writer.sv */
`timescale 1ns/100ps
`include "magic_seq_defines.svh"

module dma_cmd_writer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid,
    input  magic_seq_pkg::addr_t     cmd_addr,
    input  magic_seq_pkg::data_t     cmd_data,
    output logic                     cmd_done,
    output magic_seq_pkg::addr_t     M_AXI_AWADDR,
    output logic                     M_AXI_AWVALID,
    input  logic                     M_AXI_AWREADY,
    output magic_seq_pkg::data_t     M_AXI_WDATA,
    output logic [`MS_DATA_W/8-1:0]  M_AXI_WSTRB,
    output logic                     M_AXI_WVALID,
    input  logic                     M_AXI_WREADY,
    input  logic [1:0]               M_AXI_BRESP,
    input  logic                     M_AXI_BVALID,
    output logic                     M_AXI_BREADY
);
    import magic_seq_pkg::*;

    logic aw_ok;    // address channel empty after this edge
    logic w_ok;     // data channel empty after this edge

    assign aw_ok       = !M_AXI_AWVALID || M_AXI_AWREADY;
    assign w_ok        = !M_AXI_WVALID || M_AXI_WREADY;
    assign M_AXI_WSTRB = '1;                           // full word writes
    assign cmd_done    = M_AXI_BREADY && M_AXI_BVALID;

    ////////////////////////////////////////////////////////////////////////////
    // aw and w tracked apart, b opens once both are through
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            M_AXI_AWVALID <= 1'b0;
            M_AXI_WVALID  <= 1'b0;
            M_AXI_BREADY  <= 1'b0;
        end else if (cmd_valid) begin
            M_AXI_AWVALID <= 1'b1;
            M_AXI_WVALID  <= 1'b1;
        end else begin
            if (M_AXI_AWREADY)
                M_AXI_AWVALID <= 1'b0;
            if (M_AXI_WREADY)
                M_AXI_WVALID <= 1'b0;
            if ((M_AXI_AWVALID || M_AXI_WVALID) && aw_ok && w_ok)
                M_AXI_BREADY <= 1'b1;
            else if (M_AXI_BVALID)
                M_AXI_BREADY <= 1'b0;  // response taken
        end
    end

    // payload latched per command
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            M_AXI_AWADDR <= cmd_addr;
            M_AXI_WDATA  <= cmd_data;
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (reset)
        M_AXI_AWVALID && !M_AXI_AWREADY |=> M_AXI_AWVALID && $stable(M_AXI_AWADDR));
    a_w_stable: assert property (@(posedge clk) disable iff (reset)
        M_AXI_WVALID && !M_AXI_WREADY |=> M_AXI_WVALID && $stable(M_AXI_WDATA));

endmodule

/* verilog/magic_seq_top.sv */
`timescale 1ns/100ps
`include "magic_seq_defines.svh"

module magic_seq_top (
    input  logic                       clk,
    input  logic                       reset,

    // host side slave
    input  magic_seq_pkg::reg_addr_t   S_AXI_AWADDR,
    input  logic                       S_AXI_AWVALID,
    output logic                       S_AXI_AWREADY,
    input  magic_seq_pkg::data_t       S_AXI_WDATA,
    input  logic                       S_AXI_WVALID,
    output logic                       S_AXI_WREADY,
    output logic [1:0]                 S_AXI_BRESP,
    output logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,
    input  magic_seq_pkg::reg_addr_t   S_AXI_ARADDR,
    input  logic                       S_AXI_ARVALID,
    output logic                       S_AXI_ARREADY,
    output magic_seq_pkg::data_t       S_AXI_RDATA,
    output logic [1:0]                 S_AXI_RRESP,
    output logic                       S_AXI_RVALID,
    input  logic                       S_AXI_RREADY,

    // dma side master, write only
    output magic_seq_pkg::addr_t       M_AXI_AWADDR,
    output logic                       M_AXI_AWVALID,
    input  logic                       M_AXI_AWREADY,
    output magic_seq_pkg::data_t       M_AXI_WDATA,
    output logic [`MS_DATA_W/8-1:0]    M_AXI_WSTRB,
    output logic                       M_AXI_WVALID,
    input  logic                       M_AXI_WREADY,
    input  logic [1:0]                 M_AXI_BRESP,
    input  logic                       M_AXI_BVALID,
    output logic                       M_AXI_BREADY,

    input  logic                       slave_fin_exec  // dma finished the slot
);

    ////////////////////////////////////////////////////////////////////////////
    // internal wiring, names match the ports of every block
    ////////////////////////////////////////////////////////////////////////////

    logic set_control, set_end_cnt, set_dma_base, set_slot_field;  // host write strobes
    magic_seq_pkg::slot_idx_t wr_slot;
    logic [1:0]               wr_field;
    magic_seq_pkg::data_t     wr_data;
    magic_seq_pkg::reg_addr_t rd_addr;
    magic_seq_pkg::data_t     rd_data;

    logic                     start_pulse, busy, done;
    magic_seq_pkg::slot_idx_t end_cnt, main_cnt, slot;
    magic_seq_pkg::addr_t     dma_base, slot_src_addr, slot_dst_addr;
    magic_seq_pkg::size_t     slot_src_size, slot_dst_size;

    logic                     cmd_valid, cmd_done;  // engine to writer handshake
    magic_seq_pkg::addr_t     cmd_addr;
    magic_seq_pkg::data_t     cmd_data;

    reg_axi_write  reg_axi_write_i  (.*);
    reg_axi_read   reg_axi_read_i   (.*);
    seq_regs       seq_regs_i       (.*);
    seq_engine     seq_engine_i     (.*);
    dma_cmd_writer dma_cmd_writer_i (.*);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter realtime period = 4.0     // ns
) (
    output logic clk
);

    // free running, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

/* bench/magic_seq_tb.sv */
`timescale 1ns/100ps
`include "magic_seq_defines.svh"

module magic_seq_tb;
    import magic_seq_pkg::*;

    localparam realtime clk_period   = 4.0;
    localparam int      reset_cycles = 16;
    // 40 dma writes at up to ~25 cycles each, plus host polling and margin
    localparam int      watchdog_cycles = 5000;
    localparam data_t   size_mask = (data_t'(1) << `MS_SIZE_W) - 1;

    logic        clk, reset;
    reg_addr_t   S_AXI_AWADDR, S_AXI_ARADDR;
    data_t       S_AXI_WDATA, S_AXI_RDATA;
    logic        S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic        S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
    logic        S_AXI_RVALID, S_AXI_RREADY;
    logic [1:0]  S_AXI_BRESP, S_AXI_RRESP, M_AXI_BRESP;
    addr_t       M_AXI_AWADDR;
    data_t       M_AXI_WDATA;
    logic [3:0]  M_AXI_WSTRB;
    logic        M_AXI_AWVALID, M_AXI_AWREADY, M_AXI_WVALID, M_AXI_WREADY;
    logic        M_AXI_BVALID, M_AXI_BREADY, slave_fin_exec;

    logic [31:0] rng_state = 32'he0c3;
    data_t       tbl_raw [`MS_SLOT_COUNT][4];  // words as written by the host
    data_t       end_cnt_raw;
    addr_t       dma_base_val;
    addr_t       log_addr [$];                 // dma writes seen by the responder
    data_t       log_data [$];
    int          test_errors = 0, total_errors = 0, tests_run = 0, tests_bad = 0;

    tb_clock #(.period(clk_period)) tb_clock_i (.clk(clk));

    magic_seq_top magic_seq_top_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;  // xorshift32
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic reg_addr_t field_addr(input int s, input int f);
        return reg_addr_t'(`MS_BANK1_BASE + 16 * s + 4 * f);
    endfunction

    // the sizes keep only their low bits
    function automatic data_t slot_word(input int s, input int f);
        return (f == 1 || f == 3) ? (tbl_raw[s][f] & size_mask) : tbl_raw[s][f];
    endfunction

    function automatic addr_t dma_offset(input int f);
        case (f)
            0:       return `MS_DMA_SRC_ADDR_OFS;
            1:       return `MS_DMA_SRC_SIZE_OFS;
            2:       return `MS_DMA_DST_ADDR_OFS;
            3:       return `MS_DMA_DST_SIZE_OFS;
            default: return `MS_DMA_START_OFS;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail %s: got %h, expected %h", name, got, exp);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %0d mismatches", tests_run + 1, name, test_errors);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0)
            tests_bad++;
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // host side, driven on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic host_write(input reg_addr_t addr, input data_t data);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        do @(negedge clk); while (!S_AXI_AWREADY);
        if (S_AXI_WREADY !== 1'b1)         // both readies rise together
            report_mismatch("S_AXI_WREADY", S_AXI_WREADY, 32'h1);
        @(negedge clk);                    // beat taken on the edge just passed
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        while (!S_AXI_BVALID) @(negedge clk);
        if (S_AXI_BRESP !== 2'b00)         // OKAY even when unmapped
            report_mismatch("S_AXI_BRESP", S_AXI_BRESP, 32'h0);
        S_AXI_BREADY = 1'b1;
        @(negedge clk);
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic host_read(input reg_addr_t addr, output data_t data);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        while (!S_AXI_ARREADY) @(negedge clk);
        @(negedge clk);
        S_AXI_ARVALID = 1'b0;
        while (!S_AXI_RVALID) @(negedge clk);
        data = S_AXI_RDATA;
        if (S_AXI_RRESP !== 2'b00)
            report_mismatch("S_AXI_RRESP", S_AXI_RRESP, 32'h0);
        S_AXI_RREADY = 1'b1;
        @(negedge clk);
        S_AXI_RREADY = 1'b0;
    endtask

    // random table, end_cnt with junk above its two bits
    task automatic program_table(input int last_slot);
        for (int s = 0; s < `MS_SLOT_COUNT; s++)
            for (int f = 0; f < 4; f++) begin
                tbl_raw[s][f] = next_rand();
                host_write(field_addr(s, f), tbl_raw[s][f]);
            end
        end_cnt_raw  = (next_rand() & ~32'h3) | last_slot;
        dma_base_val = next_rand();
        host_write(`MS_REG_END_CNT, end_cnt_raw);
        host_write(`MS_REG_DMA_BASE, dma_base_val);
    endtask

    task automatic start_run;
        log_addr.delete();
        log_data.delete();
        host_write(`MS_REG_CONTROL, 32'h1);
    endtask

    task automatic wait_idle(output data_t status);
        do host_read(`MS_REG_STATUS, status); while (status[0]);  // poll busy
    endtask

    task automatic wait_for_log(input int count);
        while (log_addr.size() < count) @(negedge clk);
    endtask

    // five writes per slot, field order then the start word
    task automatic check_log(input int slots);
        addr_t exp_addr;
        data_t exp_data;
        if (log_addr.size() != 5 * slots)
            report_mismatch("dma write count", log_addr.size(), 5 * slots);
        for (int i = 0; i < log_addr.size() && i < 5 * slots; i++) begin
            exp_addr = dma_base_val + dma_offset(i % 5);
            exp_data = (i % 5 == 4) ? `MS_DMA_START_VALUE : slot_word(i / 5, i % 5);
            if (log_addr[i] !== exp_addr)
                report_mismatch("M_AXI_AWADDR", log_addr[i], exp_addr);
            if (log_data[i] !== exp_data)
                report_mismatch("M_AXI_WDATA", log_data[i], exp_data);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // dma engine model, random stalls on every channel
    ////////////////////////////////////////////////////////////////////////////

    task automatic serve_dma_write;
        int    aw_wait, w_wait, b_wait;
        bit    aw_taken, w_taken;
        bit    aw_fire, w_fire;
        addr_t addr;
        data_t data;
        aw_wait  = next_rand() % 4;
        w_wait   = next_rand() % 4;
        b_wait   = next_rand() % 4;
        aw_taken = 1'b0;
        w_taken  = 1'b0;
        while (!aw_taken || !w_taken) begin
            M_AXI_AWREADY = !aw_taken && aw_wait == 0;
            M_AXI_WREADY  = !w_taken && w_wait == 0;
            aw_fire = M_AXI_AWREADY && M_AXI_AWVALID;  // handshake on the next edge
            w_fire  = M_AXI_WREADY && M_AXI_WVALID;
            if (aw_fire)
                addr = M_AXI_AWADDR;
            if (w_fire) begin
                data = M_AXI_WDATA;
                if (M_AXI_WSTRB !== 4'hf)
                    report_mismatch("M_AXI_WSTRB", M_AXI_WSTRB, 32'hf);
            end
            @(negedge clk);
            aw_taken |= aw_fire;
            w_taken  |= w_fire;
            aw_wait  = (aw_wait > 0) ? aw_wait - 1 : 0;
            w_wait   = (w_wait > 0) ? w_wait - 1 : 0;
        end
        M_AXI_AWREADY = 1'b0;
        M_AXI_WREADY  = 1'b0;
        log_addr.push_back(addr);
        log_data.push_back(data);
        repeat (b_wait) @(negedge clk);
        while (!M_AXI_BREADY) @(negedge clk);
        M_AXI_BVALID = 1'b1;
        @(negedge clk);
        M_AXI_BVALID = 1'b0;
        if (addr == dma_base_val + `MS_DMA_START_OFS) begin  // slot kicked off
            repeat (1 + next_rand() % 8) @(negedge clk);
            slave_fin_exec = 1'b1;
            @(negedge clk);
            slave_fin_exec = 1'b0;
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!reset && M_AXI_AWVALID)
                serve_dma_write();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic readback_registers;
        data_t rd;
        host_read(`MS_REG_STATUS, rd);
        if (rd !== 0)
            report_mismatch("S_AXI_RDATA status", rd, 0);
        host_read(`MS_REG_MAIN_CNT, rd);
        if (rd !== 0)
            report_mismatch("S_AXI_RDATA main_cnt", rd, 0);
        program_table(2);
        for (int s = 0; s < `MS_SLOT_COUNT; s++)
            for (int f = 0; f < 4; f++) begin
                host_read(field_addr(s, f), rd);
                if (rd !== slot_word(s, f))
                    report_mismatch("S_AXI_RDATA slot field", rd, slot_word(s, f));
            end
        host_read(`MS_REG_END_CNT, rd);
        if (rd !== (end_cnt_raw & 32'h3))
            report_mismatch("S_AXI_RDATA end_cnt", rd, end_cnt_raw & 32'h3);
        host_read(`MS_REG_DMA_BASE, rd);
        if (rd !== dma_base_val)
            report_mismatch("S_AXI_RDATA dma_base", rd, dma_base_val);
        host_read(16'h0200, rd);                    // past the slot table
        if (rd !== 0)
            report_mismatch("S_AXI_RDATA unmapped", rd, 0);
        finish_test("register readback");
    endtask

    task automatic run_single_slot;
        data_t st;
        program_table(0);
        start_run();
        wait_idle(st);
        if (st !== 32'h2)
            report_mismatch("S_AXI_RDATA status", st, 32'h2);
        check_log(1);
        finish_test("single slot run");
    endtask

    task automatic run_four_slots;
        data_t rd;
        program_table(3);
        start_run();
        for (int k = 0; k < 4; k++) begin
            wait_for_log(5 * (k + 1));      // slot k now waits for its finish
            host_read(`MS_REG_MAIN_CNT, rd);
            if (rd !== k)
                report_mismatch("S_AXI_RDATA main_cnt", rd, k);
        end
        wait_idle(rd);
        if (rd !== 32'h2)
            report_mismatch("S_AXI_RDATA status", rd, 32'h2);
        check_log(4);
        finish_test("four slot run");
    endtask

    task automatic start_while_busy;
        data_t st;
        program_table(1);
        start_run();
        wait_for_log(2);
        host_write(`MS_REG_CONTROL, 32'h1);  // must be dropped
        wait_idle(st);
        if (st !== 32'h2)
            report_mismatch("S_AXI_RDATA status", st, 32'h2);
        check_log(2);
        finish_test("start while busy");
    endtask

    task automatic rerun_clears_done;
        data_t st;
        program_table(0);
        start_run();
        host_read(`MS_REG_STATUS, st);       // done gone, busy up
        if (st !== 32'h1)
            report_mismatch("S_AXI_RDATA status", st, 32'h1);
        wait_idle(st);
        if (st !== 32'h2)
            report_mismatch("S_AXI_RDATA status", st, 32'h2);
        check_log(1);
        finish_test("second run");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset          = 1'b1;
        S_AXI_AWADDR   = '0;
        S_AXI_AWVALID  = 1'b0;
        S_AXI_WDATA    = '0;
        S_AXI_WVALID   = 1'b0;
        S_AXI_BREADY   = 1'b0;
        S_AXI_ARADDR   = '0;
        S_AXI_ARVALID  = 1'b0;
        S_AXI_RREADY   = 1'b0;
        M_AXI_AWREADY  = 1'b0;
        M_AXI_WREADY   = 1'b0;
        M_AXI_BRESP    = 2'b00;
        M_AXI_BVALID   = 1'b0;
        slave_fin_exec = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        readback_registers();
        run_single_slot();
        run_four_slots();
        start_while_busy();
        rerun_clears_done();
        $display("summary: %0d tests, %0d with mismatches, %0d mismatches in all",
                 tests_run, tests_bad, total_errors);
        if (total_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired, the sequencer or a bus handshake stopped responding");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/magic_seq_pkg.sv
verilog/reg_axi_write.sv
verilog/reg_axi_read.sv
verilog/seq_regs.sv
verilog/seq_engine.sv
verilog/dma_cmd_writer.sv
verilog/magic_seq_top.sv
bench/tb_clock.sv
bench/magic_seq_tb.sv
